// File: common/cfg_net_pkg.sv
package cfg_net_pkg;

   // field widths of one configuration frame
   localparam int unsigned CFG_ID_BITS      = 8;
   localparam int unsigned CFG_PAYLOAD_BITS = 16;
   localparam int unsigned CFG_FRAME_BITS   = CFG_ID_BITS + CFG_PAYLOAD_BITS;

   // the serial stream as it passes from node to node
   // valid frames a packet, bit_val carries one bit per cycle
   typedef struct packed {
      logic valid;
      logic bit_val;
   } cfg_stream_s;

   // a complete frame as it sits in the receiver shift register
   // the ID goes out first, so it ends up in the upper bits
   typedef struct packed {
      logic [CFG_ID_BITS-1:0]      node_id;
      logic [CFG_PAYLOAD_BITS-1:0] payload;
   } cfg_frame_s;

   // receiver states
   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,   // waiting for valid to rise
      RX_SHIFT = 2'd1,   // collecting frame bits
      RX_DROP  = 2'd2    // frame too long, waiting for valid to fall
   } cfg_rx_state_e;

endpackage

// File: cfg_node/cfg_frame_rx.sv
`timescale 1ns/1ps

module cfg_frame_rx
   import cfg_net_pkg::*;
   (
      input  logic        clk_dst_i,
      input  logic        rst_i,
      input  cfg_stream_s cfg_i,
      output cfg_frame_s  frame_o,
      output logic        frame_done_o,
      output logic        frame_err_o
   );

   // one more than the frame length must fit, so a 25th bit can be detected
   localparam int unsigned CNT_BITS = $clog2(CFG_FRAME_BITS + 1);
   localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(CFG_FRAME_BITS);

   cfg_rx_state_e             state_q;
   cfg_rx_state_e             state_d;
   logic [CFG_FRAME_BITS-1:0] shift_q;
   logic [CNT_BITS-1:0]       cnt_q;
   logic                      done_q;
   logic                      err_q;
   logic                      shift_en;   // take bit_val into the shift register
   logic                      frame_full; // all 24 bits are in

   assign frame_full = (cnt_q == FULL_CNT);

   // next state and shift enable
   always_comb begin
      state_d  = state_q;
      shift_en = 1'b0;
      unique case (state_q)
         RX_IDLE: begin
            if (cfg_i.valid) begin
               state_d  = RX_SHIFT;
               shift_en = 1'b1;   // first bit of the new frame
            end
         end
         RX_SHIFT: begin
            if (!cfg_i.valid) begin
               state_d = RX_IDLE;
            end else if (frame_full) begin
               state_d = RX_DROP;  // a 25th bit, the frame is too long
            end else begin
               shift_en = 1'b1;
            end
         end
         RX_DROP: begin
            // bits are ignored until valid falls
            if (!cfg_i.valid) begin
               state_d = RX_IDLE;
            end
         end
         default: state_d = RX_IDLE;
      endcase
   end

   // control state and the two pulses
   always_ff @(posedge clk_dst_i) begin
      if (rst_i) begin
         state_q <= RX_IDLE;
         cnt_q   <= '0;
         done_q  <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         done_q  <= 1'b0;
         err_q   <= 1'b0;
         if (state_q == RX_IDLE && cfg_i.valid) begin
            cnt_q <= CNT_BITS'(1);
         end else if (shift_en) begin
            cnt_q <= cnt_q + 1'b1;
         end
         // a falling valid ends the frame, good or bad
         if (state_q == RX_SHIFT && !cfg_i.valid) begin
            done_q <= frame_full;
            err_q  <= !frame_full;
         end
         if (state_q == RX_DROP && !cfg_i.valid) begin
            err_q <= 1'b1;   // reported once for the whole long frame
         end
      end
   end

   // frame data, MSB first so the oldest bit moves up
   always_ff @(posedge clk_dst_i) begin
      if (shift_en) begin
         shift_q <= {shift_q[CFG_FRAME_BITS-2:0], cfg_i.bit_val};
      end
   end

   // shift_q is still untouched in the cycle the done pulse is high
   assign frame_o      = cfg_frame_s'(shift_q);
   assign frame_done_o = done_q;
   assign frame_err_o  = err_q;

endmodule

// File: cfg_node/cfg_node.sv
`timescale 1ns/1ps

module cfg_node
   import cfg_net_pkg::*;
   #(
      parameter int unsigned          NODE_ID     = 0,
      parameter int unsigned          DATA_BITS   = 8,
      parameter logic [DATA_BITS-1:0] RESET_VALUE = '0
   )
   (
      input  logic                 clk_dst_i,
      input  logic                 rst_i,
      input  cfg_stream_s          cfg_i,
      output cfg_stream_s          cfg_o,
      output logic [DATA_BITS-1:0] data_o
   );

   // own ID at the width of the frame field
   localparam logic [CFG_ID_BITS-1:0] MY_ID = CFG_ID_BITS'(NODE_ID);

   cfg_stream_s          cfg_q;        // registered copy for the next node
   cfg_frame_s           frame;
   logic                 frame_done;
   logic                 frame_err;
   logic                 id_match;
   logic                 load_en;
   logic [DATA_BITS-1:0] data_q;       // the configuration register

   // each node sees the raw stream, not its own delayed copy
   cfg_frame_rx u_frame_rx (
      .clk_dst_i    (clk_dst_i),
      .rst_i        (rst_i),
      .cfg_i        (cfg_i),
      .frame_o      (frame),
      .frame_done_o (frame_done),
      .frame_err_o  (frame_err)
   );

   // relay stage, one cycle per node along the chain
   always_ff @(posedge clk_dst_i) begin
      if (rst_i) begin
         cfg_q <= '0;   // valid low
      end else begin
         cfg_q <= cfg_i;
      end
   end

   assign cfg_o = cfg_q;

   // the address check only counts on the done pulse
   assign id_match = (frame.node_id == MY_ID);

   // a pulse of frame_err never comes with frame_done,
   // but a bad frame must never touch the register
   assign load_en = frame_done && !frame_err && id_match;

   // the register keeps the low DATA_BITS of the payload
   // upper payload bits are not stored
   always_ff @(posedge clk_dst_i) begin
      if (rst_i) begin
         data_q <= RESET_VALUE;   // each node has its own default
      end else if (load_en) begin
         data_q <= frame.payload[DATA_BITS-1:0];
      end
   end

   assign data_o = data_q;

endmodule

// File: rtl/cfg_net_top.sv
`timescale 1ns/1ps

module cfg_net_top
   import cfg_net_pkg::*;
   #(
      parameter int unsigned                          NUM_NODES    = 3,
      parameter int unsigned                          DATA_BITS    = 12,
      parameter logic [NUM_NODES-1:0][DATA_BITS-1:0] RESET_VALUES = '0
   )
   (
      input  logic                                 clk_dst_i,
      input  logic                                 rst_i,
      input  cfg_stream_s                          cfg_i,
      output cfg_stream_s                          cfg_o,
      output logic [NUM_NODES-1:0][DATA_BITS-1:0] nodes_data_o
   );

   // chain[k] is the input of node k, chain[NUM_NODES] leaves the top
   cfg_stream_s chain [NUM_NODES+1];

   assign chain[0] = cfg_i;

   // node k sees the host stream k cycles late
   for (genvar g = 0; g < NUM_NODES; g++) begin : g_node
      cfg_node #(
         .NODE_ID     (g),
         .DATA_BITS   (DATA_BITS),
         .RESET_VALUE (RESET_VALUES[g])
      ) u_node (
         .clk_dst_i (clk_dst_i),
         .rst_i     (rst_i),
         .cfg_i     (chain[g]),
         .cfg_o     (chain[g+1]),
         .data_o    (nodes_data_o[g])
      );
   end

   // the stream comes out NUM_NODES cycles after it went in
   assign cfg_o = chain[NUM_NODES];

endmodule

// File: sim/cfg_node_monitor.sv
`timescale 1ns/1ps

module cfg_node_monitor #(
   parameter int unsigned NODE_INDEX  = 0,
   parameter int unsigned DATA_BITS   = 12,
   parameter int unsigned MAX_CHANGES = 16
) (
   input  logic                                  clk_dst_i,
   input  logic                                  rst_i,
   input  logic [DATA_BITS-1:0]                  data_i,
   input  logic [MAX_CHANGES-1:0][DATA_BITS-1:0] exp_list_i,
   input  logic [7:0]                            exp_count_i,
   output logic [7:0]                            changes_o,
   output logic [7:0]                            mismatches_o
);

   logic [DATA_BITS-1:0] last_val;   // register value at the previous sample

   // the register is stable around the falling edge
   always @(negedge clk_dst_i) begin
      if (rst_i) begin
         last_val     = data_i;   // the reset default is not a change
         changes_o    = '0;
         mismatches_o = '0;
      end else if (data_i !== last_val) begin
         if (changes_o >= exp_count_i) begin
            // no further change is listed, so the old value should have stayed
            $display("FAILED t=%0t nodes_data_o[%0d]: got %h expected %h",
                     $time, NODE_INDEX, data_i, last_val);
            mismatches_o = mismatches_o + 1'b1;
         end else if (data_i !== exp_list_i[changes_o]) begin
            $display("FAILED t=%0t nodes_data_o[%0d] change %0d: got %h expected %h",
                     $time, NODE_INDEX, changes_o, data_i, exp_list_i[changes_o]);
            mismatches_o = mismatches_o + 1'b1;
         end
         changes_o = changes_o + 1'b1;
         last_val  = data_i;
      end
   end

endmodule

// File: sim/cfg_net_tb.sv
`timescale 1ns/1ps

module cfg_net_tb
   import cfg_net_pkg::*;
   ;

   localparam int unsigned NUM_NODES = 3;
   localparam int unsigned DATA_BITS = 12;
   localparam int unsigned MAX_CHG   = 16;
   localparam int          TIMEOUT   = 200;   // cycles allowed for any single wait
   localparam logic [NUM_NODES-1:0][DATA_BITS-1:0] RESET_VALUES = {
      12'hc3a, 12'h5b7, 12'h1e4
   };

   logic                                 clk_dst;
   logic                                 rst;
   cfg_stream_s                          cfg_i;
   cfg_stream_s                          cfg_o;
   logic [NUM_NODES-1:0][DATA_BITS-1:0] nodes_data_o;

   logic [NUM_NODES-1:0][DATA_BITS-1:0] model;   // expected register of each node
   logic [NUM_NODES-1:0][MAX_CHG-1:0][DATA_BITS-1:0] exp_list;
   logic [NUM_NODES-1:0][7:0]           exp_count;
   logic [NUM_NODES-1:0][7:0]           mon_changes;
   logic [NUM_NODES-1:0][7:0]           mon_mismatches;

   integer      seed;
   int          errors;
   int          relay_errors;
   int          relay_valid_cnt;
   logic        relay_en;
   cfg_stream_s cfg_hist [3];   // cfg_i one, two and three cycles back

   cfg_net_top #(
      .NUM_NODES    (NUM_NODES),
      .DATA_BITS    (DATA_BITS),
      .RESET_VALUES (RESET_VALUES)
   ) DUT (
      .clk_dst_i    (clk_dst),
      .rst_i        (rst),
      .cfg_i        (cfg_i),
      .cfg_o        (cfg_o),
      .nodes_data_o (nodes_data_o)
   );

   for (genvar g = 0; g < NUM_NODES; g++) begin : g_mon
      cfg_node_monitor #(
         .NODE_INDEX  (g),
         .DATA_BITS   (DATA_BITS),
         .MAX_CHANGES (MAX_CHG)
      ) u_mon (
         .clk_dst_i    (clk_dst),
         .rst_i        (rst),
         .data_i       (nodes_data_o[g]),
         .exp_list_i   (exp_list[g]),
         .exp_count_i  (exp_count[g]),
         .changes_o    (mon_changes[g]),
         .mismatches_o (mon_mismatches[g])
      );
   end

   initial begin
      clk_dst = 1'b0;
      forever #2 clk_dst = ~clk_dst;
   end

   // the chain output must be the host stream three cycles late
   always @(negedge clk_dst) begin
      if (relay_en) begin
         if (cfg_o !== cfg_hist[2]) begin
            $display("FAILED t=%0t cfg_o: got %b expected %b", $time, cfg_o, cfg_hist[2]);
            relay_errors++;
         end
         if (cfg_o.valid) relay_valid_cnt++;
      end
      cfg_hist[2] = cfg_hist[1];
      cfg_hist[1] = cfg_hist[0];
      cfg_hist[0] = cfg_i;
   end

   // ID goes out MSB first, then the payload, and valid drops after the last bit
   task automatic send_frame(input logic [7:0] id, input logic [15:0] payload,
                             input int len_adj);
      logic [23:0] frame;
      int          nbits;
      logic        b;
      frame = {id, payload};
      nbits = 24 + len_adj;
      for (int i = 0; i < nbits; i++) begin
         if (i < 24) b = frame[23-i];
         else b = 1'($random(seed));   // surplus bits carry noise
         @(posedge clk_dst);
         cfg_i.valid   <= 1'b1;
         cfg_i.bit_val <= b;
      end
      @(posedge clk_dst);
      cfg_i <= '0;
   endtask

   // a change is only listed when the model value really moves
   task automatic set_target(input int k, input logic [15:0] payload);
      if (payload[DATA_BITS-1:0] != model[k]) begin
         if (exp_count[k] < MAX_CHG) begin
            exp_list[k][exp_count[k]] = payload[DATA_BITS-1:0];
            exp_count[k] = exp_count[k] + 1'b1;
         end
         model[k] = payload[DATA_BITS-1:0];
      end
   endtask

   // counts cycles from the last frame bit until slice k moves
   task automatic wait_update(input int k, input logic [DATA_BITS-1:0] old_val,
                              output int cycles);
      logic done;
      done   = 1'b0;
      cycles = 1;   // the idle cycle after the frame is already running
      while (!done && cycles <= TIMEOUT) begin
         @(negedge clk_dst);
         if (nodes_data_o[k] !== old_val) begin
            done = 1'b1;
         end else begin
            @(posedge clk_dst);
            cycles++;
         end
      end
      if (!done) begin
         $display("timeout while waiting for node %0d to take its new value", k);
         errors++;
      end
   endtask

   // waits until the chain has drained and every node had time to load
   task automatic wait_idle();
      int streak;
      int n;
      streak = 0;
      n      = 0;
      while (streak < NUM_NODES + 3 && n < TIMEOUT) begin
         @(negedge clk_dst);
         n++;
         if (!cfg_o.valid) streak++;
         else streak = 0;
      end
      if (streak < NUM_NODES + 3) begin
         $display("timeout while waiting for the chain output to go idle");
         errors++;
      end
   endtask

   task automatic check_all();
      for (int k = 0; k < NUM_NODES; k++) begin
         if (nodes_data_o[k] !== model[k]) begin
            $display("FAILED t=%0t nodes_data_o[%0d]: got %h expected %h",
                     $time, k, nodes_data_o[k], model[k]);
            errors++;
         end
      end
   endtask

   task automatic test_reset_defaults();
      @(negedge clk_dst);
      for (int k = 0; k < NUM_NODES; k++) begin
         if (nodes_data_o[k] !== RESET_VALUES[k]) begin
            $display("FAILED t=%0t nodes_data_o[%0d]: got %h expected %h",
                     $time, k, nodes_data_o[k], RESET_VALUES[k]);
            errors++;
         end
      end
      if (cfg_o.valid !== 1'b0) begin
         $display("FAILED t=%0t cfg_o.valid: got %b expected 0", $time, cfg_o.valid);
         errors++;
      end
   endtask

   task automatic test_addressed_update();
      logic [15:0]          payload;
      logic [DATA_BITS-1:0] old_val;
      int                   cycles;
      for (int k = 0; k < NUM_NODES; k++) begin
         payload = 16'($random(seed));
         if (payload[DATA_BITS-1:0] == model[k]) payload[0] = ~payload[0];
         old_val = model[k];
         set_target(k, payload);
         send_frame(8'(k), payload, 0);
         wait_update(k, old_val, cycles);
         if (cycles != k + 3) begin
            $display("FAILED t=%0t update delay of nodes_data_o[%0d]: got %0d expected %0d",
                     $time, k, cycles, k + 3);
            errors++;
         end
         wait_idle();
         check_all();
      end
   endtask

   task automatic test_relay();
      logic [15:0] payload;
      payload         = 16'($random(seed));
      relay_valid_cnt = 0;
      relay_en        = 1'b1;
      set_target(1, payload);
      send_frame(8'd1, payload, 0);
      wait_idle();
      relay_en = 1'b0;
      if (relay_valid_cnt != CFG_FRAME_BITS) begin
         $display("FAILED t=%0t cfg_o valid cycles: got %0d expected %0d",
                  $time, relay_valid_cnt, CFG_FRAME_BITS);
         errors++;
      end
      check_all();
   endtask

   task automatic test_framing_errors();
      logic [15:0] payload;
      payload = ~{4'h0, model[1]};   // differs from the current value of node 1
      send_frame(8'd1, payload, -1);
      wait_idle();
      check_all();
      send_frame(8'd1, payload, 1);
      wait_idle();
      check_all();
      set_target(1, payload);   // the same frame at the right length must land
      send_frame(8'd1, payload, 0);
      wait_idle();
      check_all();
   endtask

   task automatic test_unknown_and_burst();
      logic [15:0] payload;
      int          node;
      send_frame(8'd7, 16'hffff, 0);
      wait_idle();
      check_all();
      for (int i = 0; i < 10; i++) begin
         node    = $unsigned($random(seed)) % NUM_NODES;
         payload = 16'($random(seed));
         set_target(node, payload);
         send_frame(8'(node), payload, 0);   // one idle cycle between frames
      end
      wait_idle();
      check_all();
      for (int k = 0; k < NUM_NODES; k++) begin
         if (mon_changes[k] !== exp_count[k]) begin
            $display("FAILED t=%0t monitor %0d changes: got %0d expected %0d",
                     $time, k, mon_changes[k], exp_count[k]);
            errors++;
         end
      end
   endtask

   initial begin
      int mon_total;
      seed            = 32'hda627c1e;
      errors          = 0;
      relay_errors    = 0;
      relay_valid_cnt = 0;
      relay_en        = 1'b0;
      model           = RESET_VALUES;
      exp_list        = '0;
      exp_count       = '0;
      cfg_i           = '0;
      rst             = 1'b1;
      repeat (16) @(posedge clk_dst);
      rst <= 1'b0;

      test_reset_defaults();
      test_addressed_update();
      test_relay();
      test_framing_errors();
      test_unknown_and_burst();

      mon_total = mon_mismatches[0] + mon_mismatches[1] + mon_mismatches[2];
      $display("errors: checks %0d, relay %0d, monitors %0d %0d %0d", errors, relay_errors,
               mon_mismatches[0], mon_mismatches[1], mon_mismatches[2]);
      if (errors == 0 && relay_errors == 0 && mon_total == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: sources.f
common/cfg_net_pkg.sv
cfg_node/cfg_frame_rx.sv
cfg_node/cfg_node.sv
rtl/cfg_net_top.sv
sim/cfg_node_monitor.sv
sim/cfg_net_tb.sv

// File: Bender.yml
package:
  name: cfg_net

sources:
  # package first, then the node, then the top
  - common/cfg_net_pkg.sv
  - cfg_node/cfg_frame_rx.sv
  - cfg_node/cfg_node.sv
  - rtl/cfg_net_top.sv
  - target: simulation
    files:
      - sim/cfg_node_monitor.sv
      - sim/cfg_net_tb.sv
